//--- mips_params.svh
// mips core parameters
// reset pc, register file size, datapath width and the syscall exit code
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// first fetch after reset, start of user text segment
`define MIPS_TEXT_START 32'h00400000

// architectural gp registers, $zero included
`define MIPS_NUM_REGS 32

`define MIPS_XLEN 32              // data and address width

// $v0 value that makes syscall stop the core
`define MIPS_SYSCALL_EXIT 32'd10

`endif

//--- mips_isa_pkg.sv
// mips isa package
// kept opcode and funct encodings and the three instruction formats,
// overlaid as one 32-bit word
`default_nettype none

package mips_isa_pkg;

   typedef logic [4:0] reg_idx_t;       // gp register number

   // major opcodes, bits 31:26
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,               // r-type, see funct
      OP_J       = 6'h02,
      OP_BEQ     = 6'h04,
      OP_BNE     = 6'h05,
      OP_ADDI    = 6'h08,
      OP_SLTI    = 6'h0a,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LW      = 6'h23,
      OP_SW      = 6'h2b
   } opcode_t;

   // r-type secondary opcode, bits 5:0
   typedef enum logic [5:0] {
      FN_SLL     = 6'h00,
      FN_SRL     = 6'h02,
      FN_SRA     = 6'h03,
      FN_SYSCALL = 6'h0c,
      FN_ADD     = 6'h20,
      FN_SUB     = 6'h22,
      FN_AND     = 6'h24,
      FN_OR      = 6'h25,
      FN_XOR     = 6'h26,
      FN_NOR     = 6'h27,
      FN_SLT     = 6'h2a
   } funct_t;

   typedef struct packed {
      opcode_t  op;
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t rd;
      logic [4:0] shamt;                // shift amount, sll/srl/sra only
      funct_t   funct;
   } r_fields_t;

   typedef struct packed {
      opcode_t  op;
      reg_idx_t rs;
      reg_idx_t rt;
      logic [15:0] imm;                 // immediate or offset
   } i_fields_t;

   typedef struct packed {
      opcode_t  op;
      logic [25:0] target;              // word index inside 256MB region
   } j_fields_t;

   // one fetched word, three ways to read it
   typedef union packed {
      r_fields_t r;
      i_fields_t i;
      j_fields_t j;
   } instr_u;

endpackage

`default_nettype wire

//--- mips_ctrl_pkg.sv
// mips control package
// datapath control encodings shared by decoder, alu, pc unit and top level
`default_nettype none

package mips_ctrl_pkg;

   // alu function select
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,                          // also branch compare
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOR,
      ALU_SLT,                          // signed
      ALU_SLL,
      ALU_SRL,
      ALU_SRA
   } alu_op_t;

   // register write-back source
   typedef enum logic [1:0] {
      WB_ALU,
      WB_LOAD,                          // word from data port
      WB_UPPER                          // lui, imm in bits 31:16
   } wb_sel_t;

   // next pc source
   typedef enum logic [1:0] {
      PC_SEQ,                           // pc + 4
      PC_BRANCH,
      PC_JUMP
   } pc_sel_t;

endpackage

`default_nettype wire

//--- mips_decode.sv
// mips decoder
// turns one instruction word into datapath controls and the extended
// immediate, flags halts for syscall exit and reserved encodings
`default_nettype none
`timescale 1ns/100ps
`include "mips_params.svh"

module mips_decode (
   input  mips_isa_pkg::instr_u  inst,
   input  logic [`MIPS_XLEN-1:0] v0_data,
   output mips_ctrl_pkg::alu_op_t alu_op,
   output logic                  alu_src_imm,
   output logic                  reg_dst_rd,
   output logic                  reg_we,
   output logic                  mem_we_raw,
   output logic                  branch,
   output logic                  branch_ne,
   output logic                  jump,
   output logic                  halt_req,
   output mips_ctrl_pkg::wb_sel_t wb_sel,
   output logic [`MIPS_XLEN-1:0] imm_ext
);
   import mips_isa_pkg::*;
   import mips_ctrl_pkg::*;

   logic sign_ext;                      // 0 for andi/ori/xori
   logic reserved;                      // encoding outside the kept set
   logic sys_exit;                      // syscall with exit code in $v0

   always_comb begin
      alu_op      = ALU_ADD;
      alu_src_imm = 1'b0;
      reg_dst_rd  = 1'b0;
      reg_we      = 1'b0;
      mem_we_raw  = 1'b0;
      branch      = 1'b0;
      branch_ne   = 1'b0;
      jump        = 1'b0;
      wb_sel      = WB_ALU;
      sign_ext    = 1'b1;
      reserved    = 1'b0;
      sys_exit    = 1'b0;

      case (inst.r.op)
         OP_SPECIAL: begin
            reg_dst_rd = 1'b1;          // rd is the target
            reg_we     = 1'b1;
            case (inst.r.funct)
               FN_ADD: alu_op = ALU_ADD;
               FN_SUB: alu_op = ALU_SUB;
               FN_AND: alu_op = ALU_AND;
               FN_OR:  alu_op = ALU_OR;
               FN_XOR: alu_op = ALU_XOR;
               FN_NOR: alu_op = ALU_NOR;
               FN_SLT: alu_op = ALU_SLT;
               FN_SLL: alu_op = ALU_SLL;
               FN_SRL: alu_op = ALU_SRL;
               FN_SRA: alu_op = ALU_SRA;
               FN_SYSCALL: begin
                  reg_we   = 1'b0;      // other codes fall through as a nop
                  sys_exit = (v0_data == `MIPS_SYSCALL_EXIT);
               end
               default: reserved = 1'b1;
            endcase
         end
         OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI: begin
            alu_src_imm = 1'b1;
            reg_we      = 1'b1;
            case (inst.i.op)
               OP_SLTI: alu_op = ALU_SLT;
               OP_ANDI: alu_op = ALU_AND;
               OP_ORI:  alu_op = ALU_OR;
               OP_XORI: alu_op = ALU_XOR;
               default: alu_op = ALU_ADD;
            endcase
            // logical immediates zero extend
            sign_ext = (inst.i.op == OP_ADDI) || (inst.i.op == OP_SLTI);
         end
         OP_LUI: begin
            reg_we = 1'b1;
            wb_sel = WB_UPPER;          // alu unused
         end
         OP_LW: begin
            alu_src_imm = 1'b1;         // base + offset
            reg_we      = 1'b1;
            wb_sel      = WB_LOAD;
         end
         OP_SW: begin
            alu_src_imm = 1'b1;
            mem_we_raw  = 1'b1;
         end
         OP_BEQ, OP_BNE: begin
            alu_op    = ALU_SUB;        // rs - rt, zero flag decides
            branch    = 1'b1;
            branch_ne = (inst.i.op == OP_BNE);
         end
         OP_J: jump = 1'b1;
         default: reserved = 1'b1;
      endcase

      halt_req = reserved | sys_exit;
      if (halt_req) begin
         reg_we     = 1'b0;             // halting instruction retires nothing
         mem_we_raw = 1'b0;
      end
   end

   assign imm_ext = sign_ext ? {{16{inst.i.imm[15]}}, inst.i.imm}
                             : {16'h0000, inst.i.imm};

endmodule

`default_nettype wire

//--- mips_regfile.sv
// mips register file
// 32 x 32, two combinational read ports, one write port at the clock edge,
// plus a dedicated $v0 tap for the syscall check
`default_nettype none
`timescale 1ns/100ps
`include "mips_params.svh"

module mips_regfile (
   input  logic                  clk,
   input  logic                  rst_b,
   input  mips_isa_pkg::reg_idx_t rs_idx,
   input  mips_isa_pkg::reg_idx_t rt_idx,
   input  mips_isa_pkg::reg_idx_t wr_idx,
   input  logic [`MIPS_XLEN-1:0] wr_data,
   input  logic                  we,
   output logic [`MIPS_XLEN-1:0] rs_data,
   output logic [`MIPS_XLEN-1:0] rt_data,
   output logic [`MIPS_XLEN-1:0] v0_data
);

   logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we && (wr_idx != 5'd0)) begin   // $zero stays 0
         regs[wr_idx] <= wr_data;
      end
   end

   // no write bypass, a read sees the value from before this edge
   assign rs_data = regs[rs_idx];
   assign rt_data = regs[rt_idx];
   assign v0_data = regs[2];                      // $v0

endmodule

`default_nettype wire

//--- mips_alu.sv
// mips alu
// add, sub, logic ops, signed set-less-than and shifts by a constant
// amount, with a zero flag for branch compares
`default_nettype none
`timescale 1ns/100ps
`include "mips_params.svh"

module mips_alu (
   input  logic [`MIPS_XLEN-1:0]  op_a,
   input  logic [`MIPS_XLEN-1:0]  op_b,
   input  logic [4:0]             shamt,
   input  mips_ctrl_pkg::alu_op_t alu_op,
   output logic [`MIPS_XLEN-1:0]  result,
   output logic                   zero
);
   import mips_ctrl_pkg::*;

   logic lt;                            // signed op_a < op_b

   assign lt = $signed(op_a) < $signed(op_b);

   always_comb begin
      case (alu_op)
         ALU_ADD: result = op_a + op_b;                // no overflow trap
         ALU_SUB: result = op_a - op_b;
         ALU_AND: result = op_a & op_b;
         ALU_OR:  result = op_a | op_b;
         ALU_XOR: result = op_a ^ op_b;
         ALU_NOR: result = ~(op_a | op_b);
         ALU_SLT: result = {{(`MIPS_XLEN-1){1'b0}}, lt};
         // shifts move rt, rs is not used
         ALU_SLL: result = op_b << shamt;
         ALU_SRL: result = op_b >> shamt;
         ALU_SRA: result = $unsigned($signed(op_b) >>> shamt);
         default: result = '0;
      endcase
   end

   assign zero = (result == '0);

endmodule

`default_nettype wire

//--- mips_pc_unit.sv
// mips pc unit
// program counter, next-pc selection for sequential, branch and jump flow
// (no delay slot) and the sticky halt flag
`default_nettype none
`timescale 1ns/100ps
`include "mips_params.svh"

module mips_pc_unit (
   input  logic                  clk,
   input  logic                  rst_b,
   input  logic                  branch,
   input  logic                  branch_ne,
   input  logic                  jump,
   input  logic                  zero,
   input  logic                  halt_req,
   input  logic [`MIPS_XLEN-1:0] imm_ext,
   input  logic [25:0]           target,
   output logic [`MIPS_XLEN-1:0] pc,
   output logic                  halted
);
   import mips_ctrl_pkg::*;

   logic [`MIPS_XLEN-1:0] pc_plus4;
   logic [`MIPS_XLEN-1:0] br_target;
   logic [`MIPS_XLEN-1:0] j_target;
   logic [`MIPS_XLEN-1:0] pc_next;
   pc_sel_t               pc_sel;

   assign pc_plus4  = pc + 32'd4;
   assign br_target = pc_plus4 + {imm_ext[`MIPS_XLEN-3:0], 2'b00};  // word offset
   assign j_target  = {pc[31:28], target, 2'b00};                   // same region

   always_comb begin
      if (jump) begin
         pc_sel = PC_JUMP;
      end else if (branch && (zero != branch_ne)) begin   // beq on zero, bne on !zero
         pc_sel = PC_BRANCH;
      end else begin
         pc_sel = PC_SEQ;
      end
   end

   always_comb begin
      case (pc_sel)
         PC_BRANCH: pc_next = br_target;
         PC_JUMP:   pc_next = j_target;
         default:   pc_next = pc_plus4;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc     <= `MIPS_TEXT_START;
         halted <= 1'b0;
      end else begin
         if (halt_req) begin
            halted <= 1'b1;             // sticky until reset
         end
         // pc stays on the halting instruction
         if (!halted && !halt_req) begin
            pc <= pc_next;
         end
      end
   end

endmodule

`default_nettype wire

//--- mips_core.sv
// mips single-cycle core
// fetch, decode, execute, memory and write-back all in one clock,
// word-wide instruction and data ports, halts on syscall exit or bad op
`default_nettype none
`timescale 1ns/100ps
`include "mips_params.svh"

module mips_core (
   input  logic                  clk,
   input  logic                  rst_b,
   input  logic [31:0]           inst,
   input  logic [`MIPS_XLEN-1:0] mem_rdata,
   output logic [29:0]           inst_addr,      // word address
   output logic [29:0]           mem_addr,       // word address
   output logic [`MIPS_XLEN-1:0] mem_wdata,
   output logic                  mem_we,
   output logic                  halted
);
   import mips_isa_pkg::*;
   import mips_ctrl_pkg::*;

   instr_u                inst_u;
   alu_op_t               alu_op;
   wb_sel_t               wb_sel;
   logic                  alu_src_imm, reg_dst_rd, reg_we, mem_we_raw;
   logic                  branch, branch_ne, jump, halt_req, zero;
   logic [`MIPS_XLEN-1:0] imm_ext, rs_data, rt_data, v0_data;
   logic [`MIPS_XLEN-1:0] op_b, alu_result, wr_data, pc;
   reg_idx_t              wr_idx;

   assign inst_u    = inst;
   assign inst_addr = pc[31:2];

   mips_decode decode_inst (
      .inst(inst_u), .v0_data(v0_data), .alu_op(alu_op),
      .alu_src_imm(alu_src_imm), .reg_dst_rd(reg_dst_rd), .reg_we(reg_we),
      .mem_we_raw(mem_we_raw), .branch(branch), .branch_ne(branch_ne),
      .jump(jump), .halt_req(halt_req), .wb_sel(wb_sel), .imm_ext(imm_ext)
   );

   assign wr_idx = reg_dst_rd ? inst_u.r.rd : inst_u.r.rt;   // r-type vs i-type dest

   mips_regfile regfile_inst (
      .clk(clk), .rst_b(rst_b), .rs_idx(inst_u.r.rs), .rt_idx(inst_u.r.rt),
      .wr_idx(wr_idx), .wr_data(wr_data), .we(reg_we & ~halted),
      .rs_data(rs_data), .rt_data(rt_data), .v0_data(v0_data)
   );

   assign op_b = alu_src_imm ? imm_ext : rt_data;

   mips_alu alu_inst (
      .op_a(rs_data), .op_b(op_b), .shamt(inst_u.r.shamt), .alu_op(alu_op),
      .result(alu_result), .zero(zero)
   );

   mips_pc_unit pc_unit_inst (
      .clk(clk), .rst_b(rst_b), .branch(branch), .branch_ne(branch_ne),
      .jump(jump), .zero(zero), .halt_req(halt_req), .imm_ext(imm_ext),
      .target(inst_u.j.target), .pc(pc), .halted(halted)
   );

   // write-back source
   always_comb begin
      case (wb_sel)
         WB_LOAD:  wr_data = mem_rdata;
         WB_UPPER: wr_data = {imm_ext[15:0], 16'h0000};   // lui
         default:  wr_data = alu_result;
      endcase
   end

   // data port, word aligned, low address bits dropped
   assign mem_addr  = alu_result[31:2];
   assign mem_wdata = rt_data;
   assign mem_we    = mem_we_raw & ~halted;   // no stores once stopped

endmodule

`default_nettype wire

//--- mips_core_properties.sv
// mips core properties
// once halted the core stores nothing, fetches from a fixed address and
// stays halted until reset
`default_nettype none
`timescale 1ns/100ps

module mips_core_properties (
   input logic        clk,
   input logic        rst_b,
   input logic [29:0] inst_addr,
   input logic        mem_we,
   input logic        halted
);

   store_blocked: assert property (@(posedge clk) disable iff (!rst_b) halted |-> !mem_we)
      else $error("mem_we high while halted");

   // pc frozen after the halting instruction
   fetch_frozen: assert property (@(posedge clk) disable iff (!rst_b)
                                  halted |=> $stable(inst_addr))
      else $error("inst_addr moved while halted");

   halt_sticky: assert property (@(posedge clk) disable iff (!rst_b) halted |=> halted)
      else $error("halted dropped without a reset");   // only reset clears it

endmodule

`default_nettype wire

//--- mips_core_tb.sv
// mips core testbench
// instruction and data memory models, program builder, reference alu,
// store monitor against an expected queue, and a run watchdog
`default_nettype none
`timescale 1ns/100ps
`include "mips_params.svh"

module mips_core_tb;
   import mips_isa_pkg::*;
   import mips_ctrl_pkg::*;

   localparam int IMEM_WORDS = 128;                             // longest program
   localparam logic [29:0] TEXT_WORD = 30'(`MIPS_TEXT_START >> 2);

   logic        clk;
   logic        rst_b;
   logic [31:0] inst;
   logic [31:0] mem_rdata;
   logic [31:0] mem_wdata;
   logic [29:0] inst_addr;
   logic [29:0] mem_addr;
   logic [29:0] inst_idx;
   logic        mem_we;
   logic        halted;

   logic [31:0] imem [IMEM_WORDS];
   logic [31:0] dmem [256];
   logic [29:0] exp_addr [$];                                   // store word addresses
   logic [31:0] exp_data [$];
   logic [31:0] lcg_state = 32'hc719;
   int          prog_len;

   mips_core mips_core_inst (
      .clk(clk), .rst_b(rst_b), .inst(inst), .mem_rdata(mem_rdata),
      .inst_addr(inst_addr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
      .mem_we(mem_we), .halted(halted)
   );

   bind mips_core mips_core_properties props_inst (
      .clk(clk), .rst_b(rst_b), .inst_addr(inst_addr), .mem_we(mem_we), .halted(halted)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // memories answer in the same cycle
   assign inst_idx  = inst_addr - TEXT_WORD;
   // fetches outside the text window read a reserved op
   assign inst      = (inst_idx[29:7] == '0) ? imem[inst_idx[6:0]] : {6'h3f, inst_addr[25:0]};
   assign mem_rdata = dmem[mem_addr[7:0]];

   always @(posedge clk) begin
      if (mem_we) begin
         dmem[mem_addr[7:0]] <= mem_wdata;
      end
   end

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [31:0] fill_word(input logic [7:0] idx);
      return (32'h9e3779b9 * {24'h000000, idx}) ^ 32'h0f1e2d3c;   // whole index matters
   endfunction

   // expected result straight from the isa rules
   function automatic logic [31:0] alu_ref(input alu_op_t op, input logic [31:0] a,
                                           input logic [31:0] b, input logic [4:0] sh);
      case (op)
         ALU_ADD: return a + b;
         ALU_SUB: return a - b;
         ALU_AND: return a & b;
         ALU_OR:  return a | b;
         ALU_XOR: return a ^ b;
         ALU_NOR: return ~(a | b);
         ALU_SLT: return {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};   // signed by sign bits
         ALU_SLL: return b << sh;
         ALU_SRL: return b >> sh;
         default: return (b >> sh) | (~(32'hffffffff >> sh) & {32{b[31]}});
      endcase
   endfunction

   function automatic logic [5:0] funct_for(input alu_op_t op);
      case (op)
         ALU_ADD: return FN_ADD;
         ALU_SUB: return FN_SUB;
         ALU_AND: return FN_AND;
         ALU_OR:  return FN_OR;
         ALU_XOR: return FN_XOR;
         ALU_NOR: return FN_NOR;
         ALU_SLT: return FN_SLT;
         ALU_SLL: return FN_SLL;
         ALU_SRL: return FN_SRL;
         default: return FN_SRA;
      endcase
   endfunction

   function automatic logic [31:0] r_word(input logic [5:0] fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sh);
      return {6'h00, rs, rt, rd, sh, fn};
   endfunction

   function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] j_word(input logic [31:0] dest);
      return {OP_J, dest[27:2]};                                // word index in region
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic emit_word(input logic [31:0] w);
      imem[7'(prog_len)] = w;
      prog_len++;
   endtask

   task automatic clear_program;
      prog_len = 0;
      for (int i = 0; i < IMEM_WORDS; i++) begin
         imem[7'(i)] = {6'h3f, 26'(i)};                          // reserved op halts a runaway
      end
   endtask

   task automatic load_const(input logic [4:0] rt, input logic [31:0] value);
      emit_word(i_word(OP_LUI, 5'd0, rt, value[31:16]));
      emit_word(i_word(OP_ORI, rt, rt, value[15:0]));           // ori zero extends
   endtask

   // sw rt to off($zero), queued only when the program should reach it
   task automatic store_reg(input logic [4:0] rt, input logic [15:0] off,
                            input logic [31:0] value, input bit expected);
      emit_word(i_word(OP_SW, 5'd0, rt, off));
      if (expected) begin
         exp_addr.push_back({16'h0000, off[15:2]});
         exp_data.push_back(value);
      end
   endtask

   task automatic build_main_program;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] w;
      logic [31:0] expv;
      logic [15:0] imm;
      logic [5:0]  opc;
      logic [4:0]  sh;
      logic        is_shift;
      alu_op_t     op;
      clear_program();
      for (int k = 0; k < 10; k++) begin                        // every r-type op
         op = alu_op_t'(4'(k));
         a = next_random();
         b = next_random();
         w = next_random();
         sh = w[8:4];
         is_shift = op inside {ALU_SLL, ALU_SRL, ALU_SRA};
         load_const(5'd8, a);
         load_const(5'd9, b);
         emit_word(r_word(funct_for(op), is_shift ? 5'd0 : 5'd8, 5'd9, 5'd10,
                          is_shift ? sh : 5'd0));
         store_reg(5'd10, 16'h0100 + 16'(4 * k), alu_ref(op, a, b, sh), 1'b1);
      end
      a = next_random();
      load_const(5'd8, a);
      for (int k = 0; k < 6; k++) begin                         // immediates
         w = next_random();
         imm = w[23:8];
         case (k)
            0: begin
               opc  = OP_ADDI;
               expv = alu_ref(ALU_ADD, a, {{16{imm[15]}}, imm}, 5'd0);
            end
            1: begin
               opc  = OP_SLTI;
               expv = alu_ref(ALU_SLT, a, {{16{imm[15]}}, imm}, 5'd0);
            end
            2: begin
               opc  = OP_ANDI;
               expv = alu_ref(ALU_AND, a, {16'h0000, imm}, 5'd0);
            end
            3: begin
               opc  = OP_ORI;
               expv = alu_ref(ALU_OR, a, {16'h0000, imm}, 5'd0);
            end
            4: begin
               opc  = OP_XORI;
               expv = alu_ref(ALU_XOR, a, {16'h0000, imm}, 5'd0);
            end
            default: begin
               opc  = OP_LUI;
               expv = {imm, 16'h0000};
            end
         endcase
         emit_word(i_word(opc, (opc == OP_LUI) ? 5'd0 : 5'd8, 5'd10, imm));
         store_reg(5'd10, 16'h0200 + 16'(4 * k), expv, 1'b1);
      end
      emit_word(i_word(OP_LW, 5'd0, 5'd11, 16'h0300));          // preloaded word 0xc0
      store_reg(5'd11, 16'h0304, fill_word(8'hc0), 1'b1);
      emit_word(i_word(OP_ADDI, 5'd0, 5'd12, 16'd5));
      emit_word(i_word(OP_ADDI, 5'd0, 5'd13, 16'd5));
      emit_word(i_word(OP_ADDI, 5'd0, 5'd14, 16'd7));
      emit_word(i_word(OP_BEQ, 5'd12, 5'd13, 16'd1));           // taken with no delay slot
      store_reg(5'd12, 16'h0380, 32'd5, 1'b0);
      store_reg(5'd12, 16'h0384, 32'd5, 1'b1);
      emit_word(i_word(OP_BEQ, 5'd12, 5'd14, 16'd1));           // falls through
      store_reg(5'd12, 16'h0388, 32'd5, 1'b1);
      emit_word(i_word(OP_BNE, 5'd12, 5'd14, 16'd1));           // taken
      store_reg(5'd12, 16'h038c, 32'd5, 1'b0);
      store_reg(5'd12, 16'h0390, 32'd5, 1'b1);
      emit_word(i_word(OP_BNE, 5'd12, 5'd13, 16'd1));           // falls through
      store_reg(5'd12, 16'h0394, 32'd5, 1'b1);
      emit_word(j_word(`MIPS_TEXT_START + 32'(4 * (prog_len + 2))));
      store_reg(5'd12, 16'h0398, 32'd5, 1'b0);
      store_reg(5'd12, 16'h039c, 32'd5, 1'b1);
      emit_word(i_word(OP_ADDI, 5'd0, 5'd2, 16'd10));           // $v0 = exit code
      emit_word(r_word(FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));
      store_reg(5'd12, 16'h03a0, 32'd5, 1'b0);                  // must never run
   endtask

   task automatic build_reserved_program;
      logic [31:0] w;
      clear_program();
      w = next_random();
      emit_word(i_word(OP_ADDI, 5'd0, 5'd8, w[15:0]));
      store_reg(5'd8, 16'h03a4, {{16{w[15]}}, w[15:0]}, 1'b1);
      emit_word(32'hfc000000);                                  // undefined opcode 0x3f
      store_reg(5'd8, 16'h03a8, 32'd0, 1'b0);
   endtask

   task automatic check_reset_state;
      compare_value("inst_addr", {2'b00, inst_addr}, {2'b00, TEXT_WORD});
      compare_value("halted", {31'd0, halted}, 32'd0);
      compare_value("mem_we", {31'd0, mem_we}, 32'd0);
   endtask

   task automatic apply_reset;
      @(posedge clk);
      rst_b <= 1'b0;
      repeat (2) begin
         @(negedge clk);
         check_reset_state();
         @(posedge clk);
      end
      rst_b <= 1'b1;
      @(negedge clk);
      check_reset_state();                                      // first cycle out of reset
   endtask

   // wait for halt and then expect the fetch address to stay put
   task automatic run_until_halt;
      logic [29:0] held;
      while (!halted) begin
         @(negedge clk);
      end
      held = inst_addr;
      repeat (5) begin
         @(negedge clk);
         compare_value("inst_addr", {2'b00, inst_addr}, {2'b00, held});
      end
   endtask

   // store monitor samples mid-cycle where the outputs have settled
   always @(negedge clk) begin
      if (rst_b && mem_we) begin
         if (exp_addr.size() == 0) begin
            abort_run($sformatf("unexpected store to word address 0x%h", mem_addr));
         end else begin
            compare_value("mem_addr", {2'b00, mem_addr}, {2'b00, exp_addr[0]});
            compare_value("mem_wdata", mem_wdata, exp_data[0]);
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
         end
      end
   end

   // two runs of at most IMEM_WORDS single-cycle instructions with 4x slack
   initial begin
      repeat (2 * (IMEM_WORDS * 4 + 50)) @(posedge clk);
      abort_run("timeout, the core did not halt in time");
   end

   initial begin
      rst_b <= 1'b0;
      for (int i = 0; i < 256; i++) begin
         dmem[8'(i)] <= fill_word(8'(i));
      end
      build_main_program();
      apply_reset();
      run_until_halt();
      compare_value("pending_stores", 32'(exp_addr.size()), 32'd0);
      build_reserved_program();                                 // core sits halted meanwhile
      apply_reset();
      run_until_halt();
      if (exp_addr.size() != 0) begin
         abort_run("stores expected in the program never happened");
      end else begin
         $display("Finished with no errors");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
mips_isa_pkg.sv
mips_ctrl_pkg.sv
mips_decode.sv
mips_regfile.sv
mips_alu.sv
mips_pc_unit.sv
mips_core.sv
mips_core_properties.sv
mips_core_tb.sv

//--- run.sh
#!/bin/sh
# compile with verilator, run, and decide on the printed result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module mips_core_tb -o mips_core_tb_sim &&
./obj_dir/mips_core_tb_sim | tee /dev/stderr | grep -F "Finished with no errors" > /dev/null &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
